//--- tb.f
common/texturePkg.sv
verilog/texelExpander.sv
filter/colorInterpolator.sv
filter/bilinearFilter.sv
verilog/textureFilter.sv
sim/textureFilterTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the texture filter testbench with Verilator and runs it.
# The run passes only when the log holds the pass line.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project root"
    exit 1
fi

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=textureFilterTb

rm -rf "$BUILD_DIR" "$LOG_FILE"

verilator --binary --timing \
    -f tb.f \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
SIM_STATUS=$?
cat "$LOG_FILE"
if [ $SIM_STATUS -ne 0 ]; then
    echo "Simulation exited with status $SIM_STATUS"
    exit 1
fi

grep -qxF 'All tests passed!' "$LOG_FILE"
if [ $? -ne 0 ]; then
    echo "Pass line not found in $LOG_FILE"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- sim/textureFilterTb.sv
// Random stimulus comes from a fixed LFSR seed, and the run stops at the first error
`timescale 1ns/100ps

module textureFilterTb
    import texturePkg::*;
;

    // Edges from the driving edge of a quad to the edge that presents its result
    localparam int latencyCycles = 5;
    // 16 reset cycles, about 8 gaps, 4 corners, 100 back-to-back quads,
    // 200 gapped quads at 1.5 cycles each, 2 low byte quads and the drain
    // come to about 440 cycles, so 1000 leaves a wide margin
    localparam int timeoutCycles = 1000;
    localparam logic [31:0] lfsrSeed = 32'd94592;

    logic       aclk = 1'b0;
    logic       reset;
    logic       texelValid;
    texel4444_t texel00;
    texel4444_t texel01;
    texel4444_t texel10;
    texel4444_t texel11;
    weight_t    uWeight;
    weight_t    vWeight;
    logic       filteredValid;
    pixel_t     filteredColor;

    int          cycleCount = 0;
    logic [31:0] lfsrState = lfsrSeed;

    // Quads in flight, oldest first
    string  nameQ [$];
    pixel_t colorQ [$];
    int     dueQ [$];

    textureFilter textureFilter_i (
        .aclk          (aclk),
        .reset         (reset),
        .texelValid    (texelValid),
        .texel00       (texel00),
        .texel01       (texel01),
        .texel10       (texel10),
        .texel11       (texel11),
        .uWeight       (uWeight),
        .vWeight       (vWeight),
        .filteredValid (filteredValid),
        .filteredColor (filteredColor)
    );

    always
    begin
        #4 aclk = ~aclk;
    end

    // 32 bit Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Reference widening, each nibble n becomes n * 17
    function automatic pixel_t widenRef(input texel4444_t texel);
        pixel_t wide;
        wide = '0;
        for (int ch = 0; ch < 4; ch++)
        begin
            wide[ch*8 +: 8] = subPixel_t'(17 * int'(texel[ch*4 +: 4]));
        end
        return wide;
    endfunction

    // floor((i*a + (255-i)*b + 255) / 256) clamped to 255, i is the weight's upper byte
    function automatic subPixel_t blendRef(input weight_t w, input subPixel_t a, input subPixel_t b);
        int i;
        int q;
        i = int'(w[15:8]);
        q = (i * int'(a) + (255 - i) * int'(b) + 255) / 256;
        if (q > 255)
        begin
            q = 255;
        end
        return subPixel_t'(q);
    endfunction

    function automatic pixel_t blendPixelRef(input weight_t w, input pixel_t a, input pixel_t b);
        pixel_t mixed;
        for (int ch = 0; ch < 4; ch++)
        begin
            mixed[ch*8 +: 8] = blendRef(w, a[ch*8 +: 8], b[ch*8 +: 8]);
        end
        return mixed;
    endfunction

    // Rows first with uWeight toward the right, then the column with vWeight toward the bottom
    function automatic pixel_t expectedFilter(input texel4444_t t00, input texel4444_t t01,
        input texel4444_t t10, input texel4444_t t11, input weight_t u, input weight_t v);
        pixel_t top;
        pixel_t bottom;
        top    = blendPixelRef(u, widenRef(t01), widenRef(t00));
        bottom = blendPixelRef(u, widenRef(t11), widenRef(t10));
        return blendPixelRef(v, bottom, top);
    endfunction

    task automatic takeBits(input int count, output logic [31:0] value);
        value = '0;
        for (int n = 0; n < count; n++)
        begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic randomTexel(output texel4444_t texel);
        logic [31:0] bits;
        takeBits(16, bits);
        texel = bits[15:0];
    endtask

    task automatic randomWeight(output weight_t weight);
        logic [31:0] bits;
        takeBits(16, bits);
        weight = bits[15:0];
    endtask

    task automatic endWithFailure();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkColor(input string name, input pixel_t expected, input pixel_t actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            endWithFailure();
        end
    endtask

    // Drives one quad on the next edge and records when its result is due
    task automatic offerQuad(input string name, input texel4444_t t00, input texel4444_t t01,
        input texel4444_t t10, input texel4444_t t11, input weight_t u, input weight_t v,
        input pixel_t expected);
        @(posedge aclk);
        texelValid <= 1'b1;
        texel00    <= t00;
        texel01    <= t01;
        texel10    <= t10;
        texel11    <= t11;
        uWeight    <= u;
        vWeight    <= v;
        nameQ.push_back(name);
        colorQ.push_back(expected);
        // The counter steps at this same edge, so the quad counts from cycleCount + 1
        dueQ.push_back(cycleCount + 1 + latencyCycles);
    endtask

    task automatic idleCycle();
        @(posedge aclk);
        texelValid <= 1'b0;
    endtask

    task automatic randomQuad(input string name);
        texel4444_t t00;
        texel4444_t t01;
        texel4444_t t10;
        texel4444_t t11;
        weight_t    u;
        weight_t    v;
        randomTexel(t00);
        randomTexel(t01);
        randomTexel(t10);
        randomTexel(t11);
        randomWeight(u);
        randomWeight(v);
        offerQuad(name, t00, t01, t10, t11, u, v, expectedFilter(t00, t01, t10, t11, u, v));
    endtask

    // Full weights pick one texel exactly, widened
    task automatic cornerQuads();
        texel4444_t t00;
        texel4444_t t01;
        texel4444_t t10;
        texel4444_t t11;
        randomTexel(t00);
        randomTexel(t01);
        randomTexel(t10);
        randomTexel(t11);
        offerQuad("corner11", t00, t01, t10, t11, 16'hFFFF, 16'hFFFF, widenRef(t11));
        offerQuad("corner00", t00, t01, t10, t11, 16'h0000, 16'h0000, widenRef(t00));
        offerQuad("corner01", t00, t01, t10, t11, 16'hFFFF, 16'h0000, widenRef(t01));
        offerQuad("corner10", t00, t01, t10, t11, 16'h0000, 16'hFFFF, widenRef(t10));
    endtask

    // Same quad twice with other low weight bytes, both must give one color
    task automatic lowByteQuads();
        texel4444_t t00;
        texel4444_t t01;
        texel4444_t t10;
        texel4444_t t11;
        weight_t    u;
        weight_t    v;
        pixel_t     expected;
        randomTexel(t00);
        randomTexel(t01);
        randomTexel(t10);
        randomTexel(t11);
        randomWeight(u);
        randomWeight(v);
        expected = expectedFilter(t00, t01, t10, t11, {u[15:8], 8'h00}, {v[15:8], 8'h00});
        offerQuad("lowByteZero", t00, t01, t10, t11, {u[15:8], 8'h00}, {v[15:8], 8'h00}, expected);
        offerQuad("lowByteOther", t00, t01, t10, t11, {u[15:8], 8'hA7}, {v[15:8], 8'h3C}, expected);
    endtask

    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("Run did not finish within %0d cycles", timeoutCycles);
            endWithFailure();
        end
    end

    // Outputs are sampled on the falling edge, half a period after they change
    always @(negedge aclk)
    begin
        if (!reset)
        begin
            if (filteredValid)
            begin
                if (colorQ.size() == 0)
                begin
                    $display("filteredValid was high at cycle %0d with no quad in flight", cycleCount);
                    endWithFailure();
                end
                else if (dueQ[0] != cycleCount)
                begin
                    $display("Result for %s came at cycle %0d instead of cycle %0d",
                             nameQ[0], cycleCount, dueQ[0]);
                    endWithFailure();
                end
                else
                begin
                    checkColor(nameQ.pop_front(), colorQ.pop_front(), filteredColor);
                    void'(dueQ.pop_front());
                end
            end
            else if (dueQ.size() != 0 && dueQ[0] <= cycleCount)
            begin
                $display("No result for %s at cycle %0d where it was due", nameQ[0], cycleCount);
                endWithFailure();
            end
        end
    end

    initial
    begin
        logic [31:0] gap;
        reset      = 1'b1;
        texelValid = 1'b0;
        texel00    = '0;
        texel01    = '0;
        texel10    = '0;
        texel11    = '0;
        uWeight    = '0;
        vWeight    = '0;
        repeat (16) @(posedge aclk);
        reset <= 1'b0;
        // Only gaps, nothing may come out
        repeat (8) idleCycle();
        cornerQuads();
        idleCycle();
        for (int n = 0; n < 100; n++)
        begin
            randomQuad("backToBack");
        end
        for (int n = 0; n < 200; n++)
        begin
            randomQuad("randomGap");
            takeBits(1, gap);
            if (gap[0])
            begin
                idleCycle();
            end
        end
        lowByteQuads();
        idleCycle();
        repeat (latencyCycles + 4) @(posedge aclk);
        if (colorQ.size() != 0)
        begin
            $display("%0d quads never produced a result", colorQ.size());
            endWithFailure();
        end
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

//--- verilog/textureFilter.sv
// RGBA4444 quad in and RGBA8888 pixel out five cycles later, no back-pressure so every result must be taken
`timescale 1ns/100ps

module textureFilter
    import texturePkg::*;
(
    input  logic       aclk,
    input  logic       reset,
    input  logic       texelValid,
    input  texel4444_t texel00,
    input  texel4444_t texel01,
    input  texel4444_t texel10,
    input  texel4444_t texel11,
    input  weight_t    uWeight,
    input  weight_t    vWeight,
    output logic       filteredValid,
    output pixel_t     filteredColor
);

    // Widened quad and its weights, one cycle behind the inputs
    logic    expValid;
    pixel_t  color00;
    pixel_t  color01;
    pixel_t  color10;
    pixel_t  color11;
    weight_t expUWeight;
    weight_t expVWeight;

    // Format conversion stage
    texelExpander texelExpander_i (
        .aclk       (aclk),
        .reset      (reset),
        .texelValid (texelValid),
        .texel00    (texel00),
        .texel01    (texel01),
        .texel10    (texel10),
        .texel11    (texel11),
        .uWeight    (uWeight),
        .vWeight    (vWeight),
        .expValid   (expValid),
        .color00    (color00),
        .color01    (color01),
        .color10    (color10),
        .color11    (color11),
        .expUWeight (expUWeight),
        .expVWeight (expVWeight)
    );

    // Row and column blending, four more cycles
    bilinearFilter bilinearFilter_i (
        .aclk          (aclk),
        .reset         (reset),
        .expValid      (expValid),
        .color00       (color00),
        .color01       (color01),
        .color10       (color10),
        .color11       (color11),
        .expUWeight    (expUWeight),
        .expVWeight    (expVWeight),
        .filteredValid (filteredValid),
        .filteredColor (filteredColor)
    );

endmodule

//--- filter/bilinearFilter.sv
// Four cycle latency with no back-pressure, filteredColor is undefined while filteredValid is low
`timescale 1ns/100ps

module bilinearFilter
    import texturePkg::*;
(
    input  logic    aclk,
    input  logic    reset,
    input  logic    expValid,
    input  pixel_t  color00,
    input  pixel_t  color01,
    input  pixel_t  color10,
    input  pixel_t  color11,
    input  weight_t expUWeight,
    input  weight_t expVWeight,
    output logic    filteredValid,
    output pixel_t  filteredColor
);

    // Latency of one interpolator
    localparam int mixLatency = 2;
    // Latency of the row blend followed by the column blend
    localparam int filterLatency = 2 * mixLatency;

    // Results of the two row blends, valid mixLatency cycles after the quad
    pixel_t topMix;
    pixel_t bottomMix;

    // Vertical weight delayed to line up with the row results
    weight_t vWeightDelay [mixLatency];

    // Valid flag travelling alongside the quad through all four stages
    logic [filterLatency-1:0] validShift;

    // Top row, weighted toward the right texel by uWeight
    colorInterpolator topRow (
        .aclk       (aclk),
        .intensity  (expUWeight),
        .colorA     (color01),
        .colorB     (color00),
        .mixedColor (topMix)
    );

    // Bottom row, same weighting as the top row
    colorInterpolator bottomRow (
        .aclk       (aclk),
        .intensity  (expUWeight),
        .colorA     (color11),
        .colorB     (color10),
        .mixedColor (bottomMix)
    );

    // Column blend, weighted toward the bottom row by the delayed vWeight
    colorInterpolator columnMix (
        .aclk       (aclk),
        .intensity  (vWeightDelay[mixLatency-1]),
        .colorA     (bottomMix),
        .colorB     (topMix),
        .mixedColor (filteredColor)
    );

    // Each quad keeps its own vWeight while the rows are being blended,
    // so back to back quads with different weights do not mix
    always_ff @(posedge aclk)
    begin
        vWeightDelay[0] <= expVWeight;
        for (int stage = 1; stage < mixLatency; stage++)
        begin
            vWeightDelay[stage] <= vWeightDelay[stage-1];
        end
    end

    // The interpolators have no valid flag, this shift register marks
    // which outputs belong to a real quad
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            validShift <= '0;
        end
        else
        begin
            validShift <= {validShift[filterLatency-2:0], expValid};
        end
    end

    assign filteredValid = validShift[filterLatency-1];

endmodule

//--- filter/colorInterpolator.sv
// Free-running two cycle blend with no valid flag and no reset, the caller must track which outputs count
`timescale 1ns/100ps

module colorInterpolator
    import texturePkg::*;
(
    input  logic    aclk,
    input  weight_t intensity,
    input  pixel_t  colorA,
    input  pixel_t  colorB,
    output pixel_t  mixedColor
);

    // A product of two channels needs twice the channel width
    localparam int productWidth = 2 * subPixelWidth;

    // Channel positions in the order they are processed
    localparam int channelPos [channelCount] = '{colorRPos, colorGPos, colorBPos, colorAPos};

    // Rounding bias of 255 added before the divide by 256
    localparam logic [productWidth:0] roundBias = (productWidth + 1)'(subPixelMax);

    // Weight of colorA is the upper byte of intensity
    subPixel_t weightA;
    // Weight of colorB is 1.0 minus the weight of colorA
    subPixel_t weightB;

    // First stage registers, one product per channel and color
    logic [productWidth-1:0] productA [channelCount];
    logic [productWidth-1:0] productB [channelCount];

    // The lower byte of intensity is ignored, so 0xFFFF selects colorA
    // exactly and 0x0000 selects colorB exactly
    assign weightA = intensity[$bits(weight_t)-1 -: subPixelWidth];
    assign weightB = subPixelMax - weightA;

    // Adds both weighted parts and the bias, then divides by 256
    // The sum cannot really exceed 65280, the clamp only guards bit 16
    function automatic subPixel_t roundChannel(
        input logic [productWidth-1:0] partA,
        input logic [productWidth-1:0] partB
    );
        logic [productWidth:0] sum;
        sum = {1'b0, partA} + {1'b0, partB} + roundBias;
        if (sum[productWidth])
        begin
            return subPixelMax;
        end
        return sum[productWidth-1 -: subPixelWidth];
    endfunction

    // Stage one splits both colors into channels and multiplies each
    // channel by its weight
    always_ff @(posedge aclk)
    begin
        for (int ch = 0; ch < channelCount; ch++)
        begin
            productA[ch] <= productWidth'(weightA)
                          * productWidth'(colorA[channelPos[ch] +: subPixelWidth]);
            productB[ch] <= productWidth'(weightB)
                          * productWidth'(colorB[channelPos[ch] +: subPixelWidth]);
        end
    end

    // Stage two combines the matching products and packs the channels back
    always_ff @(posedge aclk)
    begin
        for (int ch = 0; ch < channelCount; ch++)
        begin
            mixedColor[channelPos[ch] +: subPixelWidth] <= roundChannel(productA[ch], productB[ch]);
        end
    end

endmodule

//--- verilog/texelExpander.sv
// One cycle of latency, expValid is the only reset state and the payload is undefined while it is low
`timescale 1ns/100ps

module texelExpander
    import texturePkg::*;
(
    input  logic       aclk,
    input  logic       reset,
    input  logic       texelValid,
    input  texel4444_t texel00,
    input  texel4444_t texel01,
    input  texel4444_t texel10,
    input  texel4444_t texel11,
    input  weight_t    uWeight,
    input  weight_t    vWeight,
    output logic       expValid,
    output pixel_t     color00,
    output pixel_t     color01,
    output pixel_t     color10,
    output pixel_t     color11,
    output weight_t    expUWeight,
    output weight_t    expVWeight
);

    // Widens every 4 bit channel to 8 bits by repeating the nibble
    // This maps n to n * 17, so 0xF becomes 0xFF and 0x0 stays 0x00
    // Channel order is the same in both formats, so channel k of the texel
    // lands in channel k of the pixel
    function automatic pixel_t widenTexel(input texel4444_t texel);
        pixel_t wide;
        logic [texelChannelWidth-1:0] nibble;
        for (int ch = 0; ch < channelCount; ch++)
        begin
            nibble = texel[ch*texelChannelWidth +: texelChannelWidth];
            wide[ch*subPixelWidth +: subPixelWidth] = {nibble, nibble};
        end
        return wide;
    endfunction

    // Valid flag is the only control state in this stage
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            expValid <= 1'b0;
        end
        else
        begin
            expValid <= texelValid;
        end
    end

    // Widened quad and both weights move together with expValid
    // They are captured every cycle, the valid flag tells which ones count
    always_ff @(posedge aclk)
    begin
        color00    <= widenTexel(texel00);
        color01    <= widenTexel(texel01);
        color10    <= widenTexel(texel10);
        color11    <= widenTexel(texel11);
        expUWeight <= uWeight;
        expVWeight <= vWeight;
    end

endmodule

//--- common/texturePkg.sv
// Fixed RGBA4444 texel and RGBA8888 pixel layouts with red in the top channel, no other formats
package texturePkg;

    // One 8 bit color channel of a widened pixel
    typedef logic [7:0] subPixel_t;

    // RGBA8888 color with red in bits 31..24 down to alpha in bits 7..0
    typedef logic [31:0] pixel_t;

    // RGBA4444 texel, same channel order as pixel_t with red in the top nibble
    typedef logic [15:0] texel4444_t;

    // Blend weight where 0xFFFF stands for 1.0 and 0x0000 for 0.0
    // Only the upper byte takes part in the blend
    typedef logic [15:0] weight_t;

    // Channel geometry shared by the expander and the interpolator
    localparam int channelCount = 4;
    localparam int subPixelWidth = 8;
    localparam int texelChannelWidth = 4;

    // Lowest bit of each channel inside pixel_t
    localparam int colorRPos = 24;
    localparam int colorGPos = 16;
    localparam int colorBPos = 8;
    localparam int colorAPos = 0;

    // Largest channel value, which also serves as 1.0 in the blend arithmetic
    localparam subPixel_t subPixelMax = 8'hFF;

endpackage
